//--- compile.f
rtl/poly_pkg.sv
rtl/token_fifo.sv
rtl/command_decoder.sv
rtl/coef_store.sv
rtl/horner_unit.sv
rtl/firing_controller.sv
rtl/poly_actor_top.sv
tb/poly_actor_tb.sv

//--- tb/poly_actor_tb.sv
/*
  Directed testbench for the polynomial actor, acting as the parent scheduler.
  Fills the cmd/data FIFOs, fires each mode, waits for done with a timeout
  and drains result/status against a polynomial model, all modulo 2^16.
  Later tests rely on set 1 as loaded by the first test.
*/
`timescale 1ns/1ps
module poly_actor_tb
    import poly_pkg::*;
();

    localparam int CLK_PERIOD       = 20;
    localparam int WAIT_LIMIT       = 2000;
    // data tokens plus command words pushed over all six tests
    localparam int TEST_TOKENS      = 132;
    localparam int CYCLES_PER_TOKEN = 40;

    logic                 clk;
    logic                 rst;
    logic                 cmd_wr;
    logic [WORD_SIZE-1:0] cmd_in;
    logic                 data_wr;
    logic [WORD_SIZE-1:0] data_in;
    logic                 result_rd;
    logic [WORD_SIZE-1:0] result_out;
    logic                 status_rd;
    logic [WORD_SIZE-1:0] status_out;
    logic [COUNT_W-1:0]   cmd_count;
    logic [COUNT_W-1:0]   data_count;
    logic [COUNT_W-1:0]   result_count;
    logic [COUNT_W-1:0]   status_count;
    logic                 fire;
    fire_mode_e           mode;
    logic                 done;
    opcode_e              instr;

    integer               seed;
    int                   errors;
    int                   checks;
    logic [WORD_SIZE-1:0] model_coef [NUM_SETS][MAX_ORDER+1];
    int                   model_order [NUM_SETS];
    logic [WORD_SIZE-1:0] expect_q [$];

    poly_actor_top dut0 (
        .clk(clk), .rst(rst), .cmd_wr(cmd_wr), .cmd_in(cmd_in),
        .data_wr(data_wr), .data_in(data_in), .result_rd(result_rd),
        .result_out(result_out), .status_rd(status_rd), .status_out(status_out),
        .cmd_count(cmd_count), .data_count(data_count),
        .result_count(result_count), .status_count(status_count),
        .fire(fire), .mode(mode), .done(done), .instr(instr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("failure at %0t: %s", $time, what);
    endtask

    // power-series form of the polynomial c[i]*x^i
    function automatic logic [WORD_SIZE-1:0] poly_value(input int set,
                                                        input logic [WORD_SIZE-1:0] x);
        logic [WORD_SIZE-1:0] sum;
        logic [WORD_SIZE-1:0] x_pow;
        int                   i;
        sum   = '0;
        x_pow = 16'd1;
        for (i = 0; i <= model_order[set]; i++)
        begin
            sum   = sum + model_coef[set][i] * x_pow;
            x_pow = x_pow * x;
        end
        return sum;
    endfunction

    function automatic logic [WORD_SIZE-1:0] status_of(input logic [7:0] op,
                                                       input status_code_e code);
        status_word_t s;
        s.opcode = opcode_e'(op);
        s.code   = code;
        return s;
    endfunction

    function automatic command_t make_cmd(input logic [7:0] op, input int set, input int count);
        command_t c;
        c.opcode = opcode_e'(op);
        c.set_id = SET_W'(set);
        c.count  = IDX_W'(count);
        return c;
    endfunction

    function automatic logic [WORD_SIZE-1:0] rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r[WORD_SIZE-1:0];
    endfunction

    task automatic push_cmd(input command_t c);
        @(posedge clk);
        cmd_wr <= 1'b1;
        cmd_in <= c;
        @(posedge clk);
        cmd_wr <= 1'b0;
    endtask

    task automatic push_data(input logic [WORD_SIZE-1:0] w);
        @(posedge clk);
        data_wr <= 1'b1;
        data_in <= w;
        @(posedge clk);
        data_wr <= 1'b0;
    endtask

    task automatic fire_pulse(input fire_mode_e m);
        @(posedge clk);
        fire <= 1'b1;
        mode <= m;
        @(posedge clk);
        fire <= 1'b0;
    endtask

    // counts falling edges from the fire edge until done is seen
    task automatic wait_done(output int cycles);
        @(negedge clk);
        cycles = 1;
        while (!done && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!done)
        begin
            report_failure("done never pulsed after fire");
        end
    endtask

    task automatic pop_token(input bit from_status, output logic [WORD_SIZE-1:0] w);
        int waited;
        waited = 0;
        w      = '0;
        @(negedge clk);
        while ((from_status ? status_count : result_count) == '0 && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (waited >= WAIT_LIMIT)
        begin
            report_failure(from_status ? "no status word arrived" : "no result arrived");
        end
        else
        begin
            w = from_status ? status_out : result_out;
            @(posedge clk);
            if (from_status)
            begin
                status_rd <= 1'b1;
            end
            else
            begin
                result_rd <= 1'b1;
            end
            @(posedge clk);
            status_rd <= 1'b0;
            result_rd <= 1'b0;
        end
    endtask

    // get-command takes exactly two cycles with a word queued
    task automatic get_command();
        int cycles;
        @(negedge clk);
        check("cmd_count", cmd_count, 1);
        fire_pulse(MODE_GET_COMMAND);
        wait_done(cycles);
        check("done latency", cycles, 2);
        check("cmd_count", cmd_count, 0);
    endtask

    task automatic execute();
        int cycles;
        fire_pulse(MODE_EXECUTE);
        wait_done(cycles);
    endtask

    task automatic load_set(input int set, input int order);
        logic [WORD_SIZE-1:0] w;
        int                   i;
        push_cmd(make_cmd(OP_STP, set, order));
        model_order[set] = order;
        for (i = 0; i <= order; i++)
        begin
            model_coef[set][i] = rand_word();
            push_data(model_coef[set][i]);
        end
        get_command();
        execute();
        pop_token(1'b1, w);
        check("status_out", w, status_of(OP_STP, ST_OK));
    endtask

    // x must already sit in the data FIFO
    task automatic evp_loaded(input int set, input logic [WORD_SIZE-1:0] x);
        logic [WORD_SIZE-1:0] w;
        push_cmd(make_cmd(OP_EVP, set, 0));
        get_command();
        execute();
        pop_token(1'b0, w);
        check("result_out", w, poly_value(set, x));
        pop_token(1'b1, w);
        check("status_out", w, status_of(OP_EVP, ST_OK));
    endtask

    task automatic stp_then_evp();
        logic [WORD_SIZE-1:0] x;
        load_set(1, 3);
        x = rand_word();
        push_data(x);
        evp_loaded(1, x);
    endtask

    task automatic evb_batch();
        logic [WORD_SIZE-1:0] x;
        logic [WORD_SIZE-1:0] w;
        int                   i;
        for (i = 0; i < 10; i++)
        begin
            x = rand_word();
            expect_q.push_back(poly_value(1, x));
            push_data(x);
        end
        push_cmd(make_cmd(OP_EVB, 1, 10));
        get_command();
        execute();
        for (i = 0; i < 10; i++)
        begin
            pop_token(1'b0, w);
            check("result_out", w, expect_q.pop_front());
        end
        pop_token(1'b1, w);
        check("status_out", w, status_of(OP_EVB, ST_OK));
        check("data_count", data_count, 0);
    endtask

    task automatic evp_unloaded();
        logic [WORD_SIZE-1:0] w;
        push_data(rand_word());
        push_cmd(make_cmd(OP_EVP, 5, 0));
        get_command();
        execute();
        check("result_count", result_count, 0);
        check("data_count", data_count, 0);
        pop_token(1'b1, w);
        check("status_out", w, status_of(OP_EVP, ST_UNLOADED));
    endtask

    // the queued x survives the bad opcode and feeds the next EVP
    task automatic bad_opcode();
        logic [WORD_SIZE-1:0] x;
        logic [WORD_SIZE-1:0] w;
        x = rand_word();
        push_data(x);
        push_cmd(make_cmd(8'd7, 0, 0));
        get_command();
        execute();
        check("data_count", data_count, 1);
        check("result_count", result_count, 0);
        pop_token(1'b1, w);
        check("status_out", w, status_of(8'd7, ST_BAD_OPCODE));
        evp_loaded(1, x);
    endtask

    task automatic reset_clears_sets();
        logic [WORD_SIZE-1:0] w;
        load_set(2, 3);
        push_cmd(make_cmd(OP_RST, 0, 0));
        get_command();
        execute();
        check("instr", instr, OP_RST);
        check("result_count", result_count, 0);
        check("status_count", status_count, 0);
        push_data(rand_word());
        push_cmd(make_cmd(OP_EVP, 2, 0));
        get_command();
        execute();
        check("result_count", result_count, 0);
        check("data_count", data_count, 0);
        pop_token(1'b1, w);
        check("status_out", w, status_of(OP_EVP, ST_UNLOADED));
    endtask

    // 93 results for a 64-entry result FIFO stall the third EVB
    task automatic result_back_pressure();
        logic [WORD_SIZE-1:0] x;
        logic [WORD_SIZE-1:0] w;
        int                   i;
        int                   k;
        int                   waited;
        int                   cycles;
        load_set(3, 3);
        for (k = 0; k < 3; k++)
        begin
            for (i = 0; i < 31; i++)
            begin
                x = rand_word();
                expect_q.push_back(poly_value(3, x));
                push_data(x);
            end
            push_cmd(make_cmd(OP_EVB, 3, 31));
            get_command();
            if (k < 2)
            begin
                execute();
            end
            else
            begin
                fire_pulse(MODE_EXECUTE);
            end
        end
        waited = 0;
        while (result_count != FIFO_DEPTH && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (waited >= WAIT_LIMIT)
        begin
            report_failure("result FIFO never filled under back-pressure");
        end
        check("status_count", status_count, 2);
        fork
            wait_done(cycles);
            for (i = 0; i < 93; i++)
            begin
                pop_token(1'b0, w);
                check("result_out", w, expect_q.pop_front());
            end
        join
        for (k = 0; k < 3; k++)
        begin
            pop_token(1'b1, w);
            check("status_out", w, status_of(OP_EVB, ST_OK));
        end
        check("data_count", data_count, 0);
    endtask

    initial
    begin
        #(TEST_TOKENS * CYCLES_PER_TOKEN * CLK_PERIOD);
        $display("watchdog expired before the tests finished, %0d errors so far", errors);
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        seed      = 32'ha79b_9e6c;
        errors    = 0;
        checks    = 0;
        clk       = 1'b0;
        rst       = 1'b0;
        cmd_wr    = 1'b0;
        cmd_in    = '0;
        data_wr   = 1'b0;
        data_in   = '0;
        result_rd = 1'b0;
        status_rd = 1'b0;
        fire      = 1'b0;
        mode      = MODE_GET_COMMAND;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        stp_then_evp();
        evb_batch();
        evp_unloaded();
        bad_opcode();
        reset_clears_sets();
        result_back_pressure();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- rtl/poly_actor_top.sv
/*
  Polynomial evaluation actor: four token FIFOs around the firing logic.
  The parent fills cmd/data, pulses fire with a mode, waits for done
  and drains result/status. Full flags of the input FIFOs are not exported.
*/
`timescale 1ns/1ps
module poly_actor_top
    import poly_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_wr,
    input  logic [WORD_SIZE-1:0] cmd_in,
    input  logic                 data_wr,
    input  logic [WORD_SIZE-1:0] data_in,
    input  logic                 result_rd,
    output logic [WORD_SIZE-1:0] result_out,
    input  logic                 status_rd,
    output logic [WORD_SIZE-1:0] status_out,
    output logic [COUNT_W-1:0]   cmd_count,
    output logic [COUNT_W-1:0]   data_count,
    output logic [COUNT_W-1:0]   result_count,
    output logic [COUNT_W-1:0]   status_count,
    input  logic                 fire,
    input  fire_mode_e           mode,
    output logic                 done,
    output opcode_e              instr
);

    logic [WORD_SIZE-1:0] cmd_head;
    logic [WORD_SIZE-1:0] data_head;
    logic [WORD_SIZE-1:0] result_din;
    logic [WORD_SIZE-1:0] status_din;
    logic                 cmd_rd;
    logic                 cmd_empty;
    logic                 data_rd;
    logic                 data_empty;
    logic                 result_wr;
    logic                 result_full;
    logic                 status_wr;
    logic                 status_full;
    logic                 fetch;
    logic                 valid_op;
    command_t             cmd;
    logic                 coef_wr;
    logic                 clear_all;
    logic [IDX_W-1:0]     wr_index;
    logic [SET_W-1:0]     rd_set;
    logic [IDX_W-1:0]     rd_index;
    logic [WORD_SIZE-1:0] coef_q;
    logic [NUM_SETS-1:0]  loaded;
    order_array_t         set_order;
    logic                 eval_start;
    logic [WORD_SIZE-1:0] eval_x;
    logic [IDX_W-1:0]     eval_order;
    logic [WORD_SIZE-1:0] eval_value;
    logic                 eval_done;

    token_fifo cmd_fifo (
        .clk(clk), .rst(rst), .wr(cmd_wr), .din(cmd_in), .rd(cmd_rd),
        .dout(cmd_head), .count(cmd_count), .empty(cmd_empty), .full()
    );

    token_fifo data_fifo (
        .clk(clk), .rst(rst), .wr(data_wr), .din(data_in), .rd(data_rd),
        .dout(data_head), .count(data_count), .empty(data_empty), .full()
    );

    token_fifo result_fifo (
        .clk(clk), .rst(rst), .wr(result_wr), .din(result_din), .rd(result_rd),
        .dout(result_out), .count(result_count), .empty(), .full(result_full)
    );

    token_fifo status_fifo (
        .clk(clk), .rst(rst), .wr(status_wr), .din(status_din), .rd(status_rd),
        .dout(status_out), .count(status_count), .empty(), .full(status_full)
    );

    command_decoder decoder0 (
        .clk(clk), .rst(rst), .fetch(fetch), .cmd_word(cmd_head),
        .cmd_rd(cmd_rd), .cmd(cmd), .valid_op(valid_op)
    );

    coef_store store0 (
        .clk(clk), .rst(rst), .coef_wr(coef_wr), .wr_set(cmd.set_id),
        .wr_index(wr_index), .coef(data_head), .load_order(cmd.count),
        .clear_all(clear_all), .rd_set(rd_set), .rd_index(rd_index),
        .coef_q(coef_q), .order(set_order), .loaded(loaded)
    );

    horner_unit horner0 (
        .clk(clk), .rst(rst), .start(eval_start), .x(eval_x),
        .set_id(cmd.set_id), .order(eval_order), .rd_set(rd_set),
        .rd_index(rd_index), .coef_q(coef_q), .value(eval_value),
        .done(eval_done)
    );

    firing_controller ctrl0 (
        .clk(clk), .rst(rst), .fire(fire), .mode(mode),
        .cmd_empty(cmd_empty), .fetch(fetch), .cmd(cmd), .valid_op(valid_op),
        .data_in(data_head), .data_empty(data_empty), .data_rd(data_rd),
        .result_full(result_full), .status_full(status_full),
        .result_wr(result_wr), .status_wr(status_wr),
        .result_out(result_din), .status_out(status_din),
        .coef_wr(coef_wr), .wr_index(wr_index), .clear_all(clear_all),
        .loaded(loaded), .order(set_order), .eval_start(eval_start),
        .eval_x(eval_x), .eval_order(eval_order), .eval_value(eval_value),
        .eval_done(eval_done), .done(done), .instr(instr)
    );

endmodule

//--- rtl/firing_controller.sv
/*
  Firing controller of the actor, one fire per mode.
  Get-command pops and decodes one command, execute runs the held one.
  The parent fires only when enough tokens are queued; the FSM still
  stalls on an empty data FIFO or a full output FIFO. fire is ignored when busy.
*/
`timescale 1ns/1ps
module firing_controller
    import poly_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fire,
    input  fire_mode_e           mode,
    input  logic                 cmd_empty,
    output logic                 fetch,
    input  command_t             cmd,
    input  logic                 valid_op,
    input  logic [WORD_SIZE-1:0] data_in,
    input  logic                 data_empty,
    output logic                 data_rd,
    input  logic                 result_full,
    input  logic                 status_full,
    output logic                 result_wr,
    output logic                 status_wr,
    output logic [WORD_SIZE-1:0] result_out,
    output logic [WORD_SIZE-1:0] status_out,
    output logic                 coef_wr,
    output logic [IDX_W-1:0]     wr_index,
    output logic                 clear_all,
    input  logic [NUM_SETS-1:0]  loaded,
    input  order_array_t         order,
    output logic                 eval_start,
    output logic [WORD_SIZE-1:0] eval_x,
    output logic [IDX_W-1:0]     eval_order,
    input  logic [WORD_SIZE-1:0] eval_value,
    input  logic                 eval_done,
    output logic                 done,
    output opcode_e              instr
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_GET,
        S_GET_DONE,
        S_STP_LOAD,
        S_EVAL_X,
        S_EVAL_WAIT,
        S_RESULT,
        S_RST,
        S_STATUS
    } state_e;

    state_e           state;
    state_e           state_n;
    logic [IDX_W-1:0] load_cnt;
    logic [IDX_W-1:0] load_cnt_n;
    logic [IDX_W-1:0] remaining;
    logic [IDX_W-1:0] remaining_n;
    status_code_e     status_q;
    status_code_e     status_n;
    opcode_e          instr_n;
    status_word_t     status_word;
    logic             last_x;

    assign last_x      = (remaining == IDX_W'(1));
    assign wr_index    = load_cnt;
    assign eval_x      = data_in;
    assign eval_order  = order[cmd.set_id];
    assign result_out  = eval_value;
    assign status_word = '{opcode: cmd.opcode, code: status_q};
    assign status_out  = status_word;

    always_comb
    begin
        state_n     = state;
        load_cnt_n  = load_cnt;
        remaining_n = remaining;
        status_n    = status_q;
        instr_n     = instr;
        fetch       = 1'b0;
        data_rd     = 1'b0;
        result_wr   = 1'b0;
        status_wr   = 1'b0;
        coef_wr     = 1'b0;
        clear_all   = 1'b0;
        eval_start  = 1'b0;
        done        = 1'b0;
        case (state)
            S_IDLE:
            begin
                if (fire && mode == MODE_GET_COMMAND)
                begin
                    state_n = S_GET;
                end
                else if (fire && mode == MODE_EXECUTE)
                begin
                    instr_n  = cmd.opcode;
                    status_n = ST_OK;
                    if (!valid_op)
                    begin
                        status_n = ST_BAD_OPCODE;
                        state_n  = S_STATUS;
                    end
                    else
                    begin
                        case (cmd.opcode)
                            OP_STP:
                            begin
                                load_cnt_n = '0;
                                state_n    = S_STP_LOAD;
                            end
                            OP_EVP:
                            begin
                                remaining_n = IDX_W'(1);
                                state_n     = S_EVAL_X;
                            end
                            OP_EVB:
                            begin
                                remaining_n = cmd.count;
                                state_n     = (cmd.count == '0) ? S_STATUS : S_EVAL_X;
                            end
                            default: state_n = S_RST;
                        endcase
                    end
                end
            end
            S_GET:
            begin
                // wait here until a command word is present
                if (!cmd_empty)
                begin
                    fetch   = 1'b1;
                    state_n = S_GET_DONE;
                end
            end
            S_GET_DONE:
            begin
                done    = 1'b1;
                state_n = S_IDLE;
            end
            S_STP_LOAD:
            begin
                if (!data_empty)
                begin
                    data_rd = 1'b1;
                    coef_wr = 1'b1;
                    if (load_cnt == cmd.count)
                    begin
                        state_n = S_STATUS;
                    end
                    else
                    begin
                        load_cnt_n = load_cnt + 1'b1;
                    end
                end
            end
            S_EVAL_X:
            begin
                if (!data_empty)
                begin
                    data_rd = 1'b1;
                    if (loaded[cmd.set_id])
                    begin
                        eval_start = 1'b1;
                        state_n    = S_EVAL_WAIT;
                    end
                    else
                    begin
                        // unloaded set, x is consumed and dropped
                        status_n    = ST_UNLOADED;
                        remaining_n = remaining - 1'b1;
                        if (last_x)
                        begin
                            state_n = S_STATUS;
                        end
                    end
                end
            end
            S_EVAL_WAIT:
            begin
                if (eval_done)
                begin
                    state_n = S_RESULT;
                end
            end
            S_RESULT:
            begin
                if (!result_full)
                begin
                    result_wr   = 1'b1;
                    remaining_n = remaining - 1'b1;
                    state_n     = last_x ? S_STATUS : S_EVAL_X;
                end
            end
            S_RST:
            begin
                clear_all = 1'b1;
                done      = 1'b1;
                state_n   = S_IDLE;
            end
            S_STATUS:
            begin
                if (!status_full)
                begin
                    status_wr = 1'b1;
                    done      = 1'b1;
                    state_n   = S_IDLE;
                end
            end
            default: state_n = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state     <= S_IDLE;
            load_cnt  <= '0;
            remaining <= '0;
            status_q  <= ST_OK;
            instr     <= OP_STP;
        end
        else
        begin
            state     <= state_n;
            load_cnt  <= load_cnt_n;
            remaining <= remaining_n;
            status_q  <= status_n;
            instr     <= instr_n;
        end
    end

endmodule

//--- rtl/horner_unit.sv
/*
  Multi-cycle Horner evaluator, modulo 2^16.
  set_id and order are read in the start cycle, x is latched then.
  done pulses (order+1)*2 cycles after start; value holds until the next start.
*/
`timescale 1ns/1ps
module horner_unit
    import poly_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic [WORD_SIZE-1:0] x,
    input  logic [SET_W-1:0]     set_id,
    input  logic [IDX_W-1:0]     order,
    output logic [SET_W-1:0]     rd_set,
    output logic [IDX_W-1:0]     rd_index,
    input  logic [WORD_SIZE-1:0] coef_q,
    output logic [WORD_SIZE-1:0] value,
    output logic                 done
);

    typedef enum logic [1:0] {
        H_IDLE,
        H_READ,
        H_ACC
    } h_state_e;

    h_state_e             state;
    logic [WORD_SIZE-1:0] x_q;
    logic [WORD_SIZE-1:0] acc;
    logic [SET_W-1:0]     set_q;
    logic [IDX_W-1:0]     idx;

    // the start cycle already issues the read of c[N]
    assign rd_set   = (state == H_IDLE) ? set_id : set_q;
    assign rd_index = (state == H_IDLE) ? order : idx;
    assign value    = acc;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= H_IDLE;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                H_IDLE:
                begin
                    if (start)
                    begin
                        state <= H_ACC;
                    end
                end
                H_READ:  state <= H_ACC;
                H_ACC:
                begin
                    if (idx == '0)
                    begin
                        state <= H_IDLE;
                        done  <= 1'b1;
                    end
                    else
                    begin
                        state <= H_READ;
                    end
                end
                default: state <= H_IDLE;
            endcase
        end
    end

    // datapath, acc starts at zero so the first step yields c[N]
    always_ff @(posedge clk)
    begin
        if (state == H_IDLE && start)
        begin
            x_q   <= x;
            set_q <= set_id;
            idx   <= order;
            acc   <= '0;
        end
        else if (state == H_ACC)
        begin
            acc <= acc * x_q + coef_q;
            idx <= idx - 1'b1;
        end
    end

endmodule

//--- rtl/coef_store.sv
/*
  Coefficient sets with their orders and loaded flags.
  Writing index 0 records load_order and marks the set loaded, so STP
  must load c[0] first. Reads are registered, coef_q follows by one cycle.
*/
`timescale 1ns/1ps
module coef_store
    import poly_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 coef_wr,
    input  logic [SET_W-1:0]     wr_set,
    input  logic [IDX_W-1:0]     wr_index,
    input  logic [WORD_SIZE-1:0] coef,
    input  logic [IDX_W-1:0]     load_order,
    input  logic                 clear_all,
    input  logic [SET_W-1:0]     rd_set,
    input  logic [IDX_W-1:0]     rd_index,
    output logic [WORD_SIZE-1:0] coef_q,
    output order_array_t         order,
    output logic [NUM_SETS-1:0]  loaded
);

    logic [WORD_SIZE-1:0] coef_mem [NUM_SETS][MAX_ORDER+1];
    logic                 first_coef;

    assign first_coef = coef_wr && (wr_index == '0);

    always_ff @(posedge clk)
    begin
        if (coef_wr)
        begin
            coef_mem[wr_set][wr_index] <= coef;
        end
        coef_q <= coef_mem[rd_set][rd_index];
    end

    // clear_all only drops the flags, stale coefficients are harmless
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            loaded <= '0;
            order  <= '0;
        end
        else if (clear_all)
        begin
            loaded <= '0;
        end
        else if (first_coef)
        begin
            order[wr_set]  <= load_order;
            loaded[wr_set] <= 1'b1;
        end
    end

endmodule

//--- rtl/command_decoder.sv
/*
  Pops one command word per fetch and holds it until the next fetch.
  The caller asserts fetch only while the command FIFO is not empty.
  valid_op is registered with the word, so it is known one cycle later.
*/
`timescale 1ns/1ps
module command_decoder
    import poly_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fetch,
    input  logic [WORD_SIZE-1:0] cmd_word,
    output logic                 cmd_rd,
    output command_t             cmd,
    output logic                 valid_op
);

    command_t head;
    logic     known_op;

    assign head = command_t'(cmd_word);

    // pop the head in the same cycle it is captured
    assign cmd_rd = fetch;

    always_comb
    begin
        case (head.opcode)
            OP_STP,
            OP_EVP,
            OP_EVB,
            OP_RST:  known_op = 1'b1;
            default: known_op = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            cmd      <= '0;
            valid_op <= 1'b0;
        end
        else if (fetch)
        begin
            cmd      <= head;
            valid_op <= known_op;
        end
    end

endmodule

//--- rtl/token_fifo.sv
/*
  First-word-fall-through token queue with an occupancy count.
  dout shows the head word whenever empty is low.
  Writes while full and reads while empty are dropped.
*/
`timescale 1ns/1ps
module token_fifo
    import poly_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wr,
    input  logic [WORD_SIZE-1:0] din,
    input  logic                 rd,
    output logic [WORD_SIZE-1:0] dout,
    output logic [COUNT_W-1:0]   count,
    output logic                 empty,
    output logic                 full
);

    logic [WORD_SIZE-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic                 do_wr;
    logic                 do_rd;

    assign empty = (count == '0);
    assign full  = (count == COUNT_W'(FIFO_DEPTH));
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;
    assign dout  = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_wr)
        begin
            mem[wr_ptr] <= din;
        end
    end

    // pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_wr)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- rtl/poly_pkg.sv
/*
  Shared sizes, encodings and token formats for the polynomial actor.
  All arithmetic is unsigned and wraps modulo 2^16.
  Command word layout: opcode[15:8], set_id[7:5], count[4:0].
  Status word layout: opcode[15:8] echoed from the command, code[7:0].
*/
package poly_pkg;

    localparam int WORD_SIZE  = 16;
    localparam int NUM_SETS   = 8;
    localparam int MAX_ORDER  = 31;
    localparam int FIFO_DEPTH = 64;
    localparam int COUNT_W    = 7;

    // derived field widths
    localparam int SET_W = $clog2(NUM_SETS);
    localparam int IDX_W = $clog2(MAX_ORDER + 1);
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // any value outside this list is a bad opcode
    typedef enum logic [7:0] {
        OP_STP = 8'd0,
        OP_EVP = 8'd1,
        OP_EVB = 8'd2,
        OP_RST = 8'd3
    } opcode_e;

    typedef enum logic [1:0] {
        MODE_GET_COMMAND = 2'd0,
        MODE_EXECUTE     = 2'd1
    } fire_mode_e;

    typedef enum logic [7:0] {
        ST_OK         = 8'd0,
        ST_UNLOADED   = 8'd1,
        ST_BAD_OPCODE = 8'd2
    } status_code_e;

    // count is the order N for STP and b for EVB
    typedef struct packed {
        opcode_e          opcode;
        logic [SET_W-1:0] set_id;
        logic [IDX_W-1:0] count;
    } command_t;

    typedef struct packed {
        opcode_e      opcode;
        status_code_e code;
    } status_word_t;

    // per-set polynomial order
    typedef logic [NUM_SETS-1:0][IDX_W-1:0] order_array_t;

endpackage
